// ==== source/byte_fifo.sv ====
`timescale 1ns/1ps

module byte_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                push,
    input  byte_link_pkg::sym_t push_data,
    output byte_link_pkg::sym_t fifo_data,
    output logic                fifo_valid,
    input  logic                fifo_pop,
    output logic                credit_return
);
    import byte_link_pkg::*;

    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int FILL_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

    sym_t              mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [FILL_W-1:0] fill;
    logic              do_pop;

    assign do_pop     = fifo_pop && fifo_valid;
    assign fifo_valid = (fill != '0);
    assign fifo_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            fill          <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, do_pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            // Freed slot goes back to the sender next cycle.
            credit_return <= do_pop;
        end
    end

endmodule

// ==== source/byte_link_consts.svh ====
`ifndef BYTE_LINK_CONSTS_SVH
`define BYTE_LINK_CONSTS_SVH

// Word and channel geometry.
`define BL_CHANNEL_WIDTH 8
`define BL_SINK_SYMBOLS 2

// Receive buffer depth, which is also the number of credits after reset.
`define BL_CREDITS 4

// Link control codes.
`define BL_CHANNEL_CODE 8'h7C
`define BL_ESCAPE_CODE 8'h7D
`define BL_CONTROL_LOW 8'h7A
`define BL_CONTROL_HIGH 8'h7D

// An escaped byte goes out as its value XOR this mask.
`define BL_ESCAPE_XOR 8'h20

`endif

// ==== source/byte_link_pkg.sv ====
`include "byte_link_consts.svh"

package byte_link_pkg;

    typedef logic [7:0] sym_t;
    typedef logic [`BL_CHANNEL_WIDTH-1:0] chan_t;
    typedef logic [8*`BL_SINK_SYMBOLS-1:0] word_t;
    typedef logic [$clog2(`BL_CREDITS + 1)-1:0] credit_t;
    typedef logic [((`BL_SINK_SYMBOLS > 1) ? $clog2(`BL_SINK_SYMBOLS) : 1)-1:0] sym_index_t;

    typedef enum logic [1:0] {
        STUFF_IDLE,
        STUFF_CHANNEL,
        STUFF_DATA
    } stuff_state_t;

    typedef enum logic [1:0] {
        HUNT,
        GET_CHANNEL,
        GET_DATA
    } unstuff_state_t;

    // True for any byte that must be escaped on the link.
    function automatic logic is_control(input sym_t value);
        return (value >= `BL_CONTROL_LOW) && (value <= `BL_CONTROL_HIGH);
    endfunction

endpackage

// ==== source/byte_link_top.sv ====
`timescale 1ns/1ps
`include "byte_link_consts.svh"

module byte_link_top (
    input  logic                 clk,
    input  logic                 reset,
    input  byte_link_pkg::word_t in_data,
    input  byte_link_pkg::chan_t in_channel,
    input  logic                 in_valid,
    output logic                 in_ready,
    output byte_link_pkg::word_t out_data,
    output byte_link_pkg::chan_t out_channel,
    output logic                 out_valid,
    input  logic                 out_ready
);
    import byte_link_pkg::*;

    sym_t link_data;
    logic link_valid;
    logic link_ready;
    logic link_push;
    sym_t fifo_data;
    logic fifo_valid;
    logic fifo_pop;
    logic credit_return;

    // A byte crosses the link when the sender holds a credit.
    assign link_push = link_valid && link_ready;

    byte_stuffer stuffer0 (
        .clk        (clk),
        .reset      (reset),
        .in_data    (in_data),
        .in_channel (in_channel),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .link_data  (link_data),
        .link_valid (link_valid),
        .link_ready (link_ready)
    );

    link_credit_ctrl credit0 (
        .clk           (clk),
        .reset         (reset),
        .link_valid    (link_valid),
        .link_ready    (link_ready),
        .credit_return (credit_return)
    );

    byte_fifo #(
        .DEPTH (`BL_CREDITS)
    ) fifo0 (
        .clk           (clk),
        .reset         (reset),
        .push          (link_push),
        .push_data     (link_data),
        .fifo_data     (fifo_data),
        .fifo_valid    (fifo_valid),
        .fifo_pop      (fifo_pop),
        .credit_return (credit_return)
    );

    byte_unstuffer unstuffer0 (
        .clk         (clk),
        .reset       (reset),
        .fifo_data   (fifo_data),
        .fifo_valid  (fifo_valid),
        .fifo_pop    (fifo_pop),
        .out_data    (out_data),
        .out_channel (out_channel),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

endmodule

// ==== source/byte_stuffer.sv ====
`timescale 1ns/1ps
`include "byte_link_consts.svh"

module byte_stuffer (
    input  logic                 clk,
    input  logic                 reset,
    input  byte_link_pkg::word_t in_data,
    input  byte_link_pkg::chan_t in_channel,
    input  logic                 in_valid,
    output logic                 in_ready,
    output byte_link_pkg::sym_t  link_data,
    output logic                 link_valid,
    input  logic                 link_ready
);
    import byte_link_pkg::*;

    localparam sym_index_t LAST_INDEX = sym_index_t'(`BL_SINK_SYMBOLS - 1);

    stuff_state_t state;
    logic         escaped;
    sym_index_t   sym_index;
    word_t        word_q;
    chan_t        chan_q;

    logic accept;
    logic send;
    sym_t cur_byte;
    logic cur_is_ctrl;
    logic need_escape;
    sym_t next_byte;

    assign accept = in_valid && in_ready;
    assign send   = link_valid && link_ready;

    // Byte that the state says goes out next, before escaping.
    always_comb begin
        if (state == STUFF_CHANNEL) begin
            cur_byte = sym_t'(chan_q);
        end else begin
            cur_byte = word_q[8*sym_index +: 8];
        end
        cur_is_ctrl = is_control(cur_byte);
        need_escape = cur_is_ctrl && !escaped;
        if (need_escape) begin
            next_byte = `BL_ESCAPE_CODE;
        end else if (cur_is_ctrl) begin
            next_byte = cur_byte ^ `BL_ESCAPE_XOR;
        end else begin
            next_byte = cur_byte;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            in_ready   <= 1'b1;
            link_valid <= 1'b0;
            state      <= STUFF_IDLE;
            escaped    <= 1'b0;
            sym_index  <= '0;
        end else if (accept) begin
            // Marker goes out first.
            in_ready   <= 1'b0;
            link_valid <= 1'b1;
            state      <= STUFF_CHANNEL;
            escaped    <= 1'b0;
        end else if (send) begin
            case (state)
                STUFF_CHANNEL, STUFF_DATA: begin
                    if (need_escape) begin
                        escaped <= 1'b1;
                    end else begin
                        escaped <= 1'b0;
                        if (state == STUFF_CHANNEL) begin
                            sym_index <= '0;
                            state     <= STUFF_DATA;
                        end else begin
                            sym_index <= sym_index_t'(sym_index + 1'b1);
                            if (sym_index == LAST_INDEX) begin
                                state <= STUFF_IDLE;
                            end
                        end
                    end
                end
                default: begin
                    // Last data byte has gone, ready for the next word.
                    in_ready   <= 1'b1;
                    link_valid <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            word_q    <= in_data;
            chan_q    <= in_channel;
            link_data <= `BL_CHANNEL_CODE;
        end else if (send && (state != STUFF_IDLE)) begin
            link_data <= next_byte;
        end
    end

endmodule

// ==== source/byte_unstuffer.sv ====
`timescale 1ns/1ps
`include "byte_link_consts.svh"

module byte_unstuffer (
    input  logic                 clk,
    input  logic                 reset,
    input  byte_link_pkg::sym_t  fifo_data,
    input  logic                 fifo_valid,
    output logic                 fifo_pop,
    output byte_link_pkg::word_t out_data,
    output byte_link_pkg::chan_t out_channel,
    output logic                 out_valid,
    input  logic                 out_ready
);
    import byte_link_pkg::*;

    localparam sym_index_t LAST_INDEX = sym_index_t'(`BL_SINK_SYMBOLS - 1);

    unstuff_state_t state;
    logic           pending;
    sym_index_t     sym_index;

    logic is_marker;
    logic is_escape;
    sym_t value;
    logic store_channel;
    logic store_data;

    // Stall only while a finished word waits to be taken.
    assign fifo_pop = fifo_valid && !(out_valid && !out_ready);

    assign is_marker = (fifo_data == `BL_CHANNEL_CODE);
    assign is_escape = (fifo_data == `BL_ESCAPE_CODE) && !pending;

    always_comb begin
        value         = pending ? (fifo_data ^ `BL_ESCAPE_XOR) : fifo_data;
        store_channel = 1'b0;
        store_data    = 1'b0;
        if (fifo_pop && !is_control(fifo_data)) begin
            store_channel = (state == GET_CHANNEL);
            store_data    = (state == GET_DATA);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= HUNT;
            pending   <= 1'b0;
            sym_index <= '0;
            out_valid <= 1'b0;
        end else begin
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
            if (fifo_pop) begin
                if (is_marker) begin
                    // A marker always starts a fresh frame.
                    state   <= GET_CHANNEL;
                    pending <= 1'b0;
                end else if (state == HUNT) begin
                    pending <= 1'b0;
                end else if (is_escape) begin
                    pending <= 1'b1;
                end else if (is_control(fifo_data)) begin
                    state   <= HUNT;
                    pending <= 1'b0;
                end else if (state == GET_CHANNEL) begin
                    pending   <= 1'b0;
                    sym_index <= '0;
                    state     <= GET_DATA;
                end else begin
                    pending   <= 1'b0;
                    sym_index <= sym_index_t'(sym_index + 1'b1);
                    if (sym_index == LAST_INDEX) begin
                        state     <= HUNT;
                        out_valid <= 1'b1;
                    end
                end
            end
        end
    end

    // Word is built in place, low byte first.
    always_ff @(posedge clk) begin
        if (store_channel) begin
            out_channel <= chan_t'(value);
        end
        if (store_data) begin
            out_data[8*sym_index +: 8] <= value;
        end
    end

endmodule

// ==== source/link_credit_ctrl.sv ====
`timescale 1ns/1ps
`include "byte_link_consts.svh"

module link_credit_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic link_valid,
    output logic link_ready,
    input  logic credit_return
);
    import byte_link_pkg::*;

    credit_t credits;
    logic    send;

    assign send = link_valid && link_ready;

    // One credit per free byte in the receive buffer.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credits <= credit_t'(`BL_CREDITS);
        end else begin
            case ({send, credit_return})
                2'b10: begin
                    credits <= credit_t'(credits - 1'b1);
                end
                2'b01: begin
                    credits <= credit_t'(credits + 1'b1);
                end
                default: begin
                    credits <= credits;
                end
            endcase
        end
    end

    // The link may carry a byte only while a credit is held.
    assign link_ready = (credits != '0);

endmodule

// ==== sources.f ====
+incdir+source
+incdir+verification
source/byte_link_pkg.sv
source/byte_stuffer.sv
source/link_credit_ctrl.sv
source/byte_fifo.sv
source/byte_unstuffer.sv
source/byte_link_top.sv
verification/tb_byte_link.sv

// ==== verification/tb_byte_link_checks.svh ====
`ifndef TB_BYTE_LINK_CHECKS_SVH
`define TB_BYTE_LINK_CHECKS_SVH

// First error ends the run.
task automatic halt_on_error(input string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1);
endtask

task automatic compare_word(input string name, input word_t got, input word_t expected);
    if (got !== expected) begin
        halt_on_error($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, expected));
    end
endtask

task automatic compare_channel(input string name, input chan_t got, input chan_t expected);
    if (got !== expected) begin
        halt_on_error($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, expected));
    end
endtask

task automatic compare_flag(input string name, input logic got, input logic expected);
    if (got !== expected) begin
        halt_on_error($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, expected));
    end
endtask

`endif

// ==== verification/tb_byte_link.sv ====
`timescale 1ns/1ps
`include "byte_link_consts.svh"

module tb_byte_link;
    import byte_link_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int PLAIN_WORDS  = 41;
    localparam int ESCAPE_WORDS = 14;
    localparam int HOLD_WORDS   = 3;
    localparam int RANDOM_WORDS = 300;
    // Clearing bit 6 keeps every byte out of 0x7A..0x7D.
    localparam word_t PLAIN_MASK = {`BL_SINK_SYMBOLS{8'hbf}};

    logic        clk;
    logic        reset;
    word_t       in_data;
    chan_t       in_channel;
    logic        in_valid;
    logic        in_ready;
    word_t       out_data;
    chan_t       out_channel;
    logic        out_valid;
    logic        out_ready;
    logic [31:0] rng_state;
    logic        ready_random;
    word_t       exp_words[$];
    chan_t       exp_chans[$];

    `include "tb_byte_link_checks.svh"

    byte_link_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Budget of 40 clock cycles per planned word.
    initial begin
        #((PLAIN_WORDS + ESCAPE_WORDS + HOLD_WORDS + RANDOM_WORDS) * 40 * CLK_PERIOD);
        halt_on_error("Run timed out before all tests finished");
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Inputs change 1 ns after the rising edge.
    task automatic step_cycle();
        @(posedge clk);
        #1;
        if (ready_random) begin
            out_ready = (next_random() & 32'h100) != 0;
        end
    endtask

    task automatic send_word(input word_t data, input chan_t chan);
        in_data    = data;
        in_channel = chan;
        in_valid   = 1'b1;
        while (!in_ready) step_cycle();
        exp_words.push_back(data);
        exp_chans.push_back(chan);
        step_cycle();
        in_valid = 1'b0;
    endtask

    // Each accepted output must equal the oldest word still queued.
    always @(posedge clk) begin
        if (!reset && out_valid && out_ready) begin
            if (exp_words.size() == 0) begin
                halt_on_error("DUT delivered a word that was never sent");
            end else begin
                compare_channel("out_channel", out_channel, exp_chans.pop_front());
                compare_word("out_data", out_data, exp_words.pop_front());
            end
        end
    end

    task automatic test_reset_state();
        reset = 1'b1;
        repeat (15) step_cycle();
        compare_flag("out_valid", out_valid, 1'b0);
        compare_flag("in_ready", in_ready, 1'b1);
        step_cycle();
        reset = 1'b0;
        step_cycle();
        compare_flag("out_valid", out_valid, 1'b0);
        compare_flag("in_ready", in_ready, 1'b1);
    endtask

    task automatic test_plain_round_trip();
        out_ready = 1'b1;
        // Bytes just outside the control range.
        send_word(16'h7e79, 8'h7e);
        for (int i = 1; i < PLAIN_WORDS; i++) begin
            send_word(word_t'(next_random()) & PLAIN_MASK, chan_t'(next_random()) & 8'hbf);
        end
        while (exp_words.size() != 0) step_cycle();
    endtask

    // Each control code as channel, low byte, high byte and whole word.
    task automatic test_escaping();
        sym_t code;
        out_ready = 1'b1;
        for (int i = 0; i < 4; i++) begin
            code = sym_t'(8'h7a + i);
            send_word({code, code}, code);
            send_word({8'h41, code}, 8'h05);
            send_word({code, 8'h5c}, 8'h06);
        end
        send_word(16'h7d7c, 8'h7b);
        send_word(16'h7a7d, 8'h7c);
        while (exp_words.size() != 0) step_cycle();
    endtask

    // One word held at the output, one in the buffer, one in the stuffer at most.
    task automatic test_back_pressure();
        int accepted;
        accepted   = 0;
        out_ready  = 1'b0;
        in_data    = word_t'(next_random()) & PLAIN_MASK;
        in_channel = chan_t'(next_random()) & 8'hbf;
        in_valid   = 1'b1;
        repeat (200) begin
            if (in_ready) begin
                exp_words.push_back(in_data);
                exp_chans.push_back(in_channel);
                accepted++;
                step_cycle();
                in_data    = word_t'(next_random()) & PLAIN_MASK;
                in_channel = chan_t'(next_random()) & 8'hbf;
            end else begin
                step_cycle();
            end
        end
        in_valid = 1'b0;
        if (accepted < 2 || accepted > HOLD_WORDS) begin
            halt_on_error($sformatf("Stalled output let %0d words in, expected 2 to %0d",
                                    accepted, HOLD_WORDS));
        end
        out_ready = 1'b1;
        while (exp_words.size() != 0) step_cycle();
    endtask

    task automatic test_random_traffic();
        ready_random = 1'b1;
        for (int i = 0; i < RANDOM_WORDS; i++) begin
            send_word(word_t'(next_random()), chan_t'(next_random()));
        end
        while (exp_words.size() != 0) step_cycle();
        ready_random = 1'b0;
        out_ready    = 1'b1;
    endtask

    initial begin
        reset        = 1'b1;
        in_data      = '0;
        in_channel   = '0;
        in_valid     = 1'b0;
        out_ready    = 1'b0;
        ready_random = 1'b0;
        rng_state    = 32'h11aa52af;
        test_reset_state();
        test_plain_round_trip();
        test_escaping();
        test_back_pressure();
        test_random_traffic();
        $display("No errors");
        $finish;
    end

endmodule
